// ==== Makefile ====
# Verilator build and run of the F100 CPU testbench

TOP       ?= f100_tb
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0
OBJ_DIR   ?= obj_dir

SOURCES := common/f100_settings.svh common/f100_isa_pkg.sv common/f100_bus_pkg.sv \
           core/f100_alu.sv core/f100_control.sv hw/mem_credit_port.sv hw/f100_cpu.sv \
           bench/f100_tb.sv bench/f100_tb_tests.svh

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): vlog.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f

# Passes only when the simulation prints the pass line
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/f100_tb_tests.svh ====
// Pattern for unused words depends on every address bit
function automatic logic [W-1:0] fill_word(input logic [W-1:0] addr);
  return {addr[7:0], addr[15:8]} ^ 16'h9c3b;
endfunction

function automatic logic [W-1:0] mem_ref(input f100_op_e op, input logic [10:0] n);
  f100_instr_t instr;
  instr.op = op;
  instr.i  = 1'b0;
  instr.n  = n;
  return instr;
endfunction

task automatic emit(input logic [W-1:0] word);
  boot_image[prog_addr] = word;
  prog_addr = prog_addr + 16'd1;
endtask

// Fresh image with the link stack at LSP_START and code at the reset PC
task automatic begin_program(input string name);
  int a;
  for (a = 0; a < 65536; a++)
    boot_image[a[15:0]] = fill_word(a[15:0]);
  boot_image[`F100_LSP_ADDR] = LSP_START;
  prog_addr           = `F100_RESET_PC;
  test_name           = name;
  test_errors         = 0;
  bus_errors_at_start = bus_errors;
endtask

task automatic pulse_reset();
  @(negedge raw_clk);
  button_reset = 1'b0;
  repeat (10) @(negedge raw_clk);
  button_reset = 1'b1;
endtask

task automatic run_to_halt();
  pulse_reset();
  while (!halted)
    @(negedge raw_clk);
endtask

task automatic report_test();
  int errors;
  errors = test_errors + bus_errors - bus_errors_at_start;
  tests_run++;
  if (errors == 0)
    $display("%s: passed", test_name);
  else
  begin
    $display("%s: %0d errors", test_name, errors);
    test_fails++;
  end
endtask

task automatic lda_sto_moves();
  begin_program("lda_sto_moves");
  boot_image[16'h0200] = 16'hc35a;
  emit(mem_ref(OP_LDA, 11'h200));
  emit(mem_ref(OP_STO, 11'h201));
  emit(mem_ref(OP_LDA, 11'h000));
  emit(16'h1234);
  emit(mem_ref(OP_STO, 11'h202));
  emit(HALT_WORD);
  run_to_halt();
  check_word("lda_sto direct", 16'hc35a, mem_words[16'h0201]);
  check_word("lda_sto immediate", 16'h1234, mem_words[16'h0202]);
  report_test();
endtask

// Accumulator a, memory operand b
task automatic alu_results();
  logic [W-1:0] a;
  logic [W-1:0] b;
  a = 16'h1234;
  b = 16'h0f0f;
  begin_program("alu_results");
  boot_image[16'h0200] = b;
  emit(mem_ref(OP_LDA, 11'h000));
  emit(a);
  emit(mem_ref(OP_ADD, 11'h200));
  emit(mem_ref(OP_STO, 11'h210));
  emit(mem_ref(OP_LDA, 11'h000));
  emit(a);
  emit(mem_ref(OP_SUB, 11'h200));
  emit(mem_ref(OP_STO, 11'h211));
  emit(mem_ref(OP_LDA, 11'h000));
  emit(a);
  emit(mem_ref(OP_AND, 11'h000));
  emit(b);
  emit(mem_ref(OP_STO, 11'h212));
  emit(mem_ref(OP_LDA, 11'h000));
  emit(a);
  emit(mem_ref(OP_NEQ, 11'h200));
  emit(mem_ref(OP_STO, 11'h213));
  emit(HALT_WORD);
  run_to_halt();
  check_word("add", b + a, mem_words[16'h0210]);
  check_word("sub operand minus acc", b - a, mem_words[16'h0211]);
  check_word("and", a & b, mem_words[16'h0212]);
  check_word("neq", a ^ b, mem_words[16'h0213]);
  report_test();
endtask

task automatic flag_push();
  f100_cr_t add_cr;
  f100_cr_t sub_cr;
  begin_program("flag_push");
  emit(mem_ref(OP_LDA, 11'h000));
  emit(16'h0001);
  emit(mem_ref(OP_ADD, 11'h000));
  emit(16'h7fff);
  emit(mem_ref(OP_CAL, 11'h000));
  emit(16'h0040);
  prog_addr = 16'h0040;
  emit(mem_ref(OP_LDA, 11'h000));
  emit(16'h0005);
  emit(mem_ref(OP_SUB, 11'h000));
  emit(16'h0005);
  emit(mem_ref(OP_CAL, 11'h000));
  emit(16'h0050);
  prog_addr = 16'h0050;
  emit(HALT_WORD);
  run_to_halt();
  // 7FFF + 1 gives 8000 with no carry
  // Positive operands with a negative sum set V
  add_cr   = '0;
  add_cr.s = 1'b1;
  add_cr.v = 1'b1;
  // 5 - 5 gives zero with no borrow and clears the V left by the ADD
  sub_cr   = '0;
  sub_cr.z = 1'b1;
  check_cr("flags after ADD", add_cr, f100_cr_t'(mem_words[LSP_START + 16'd2]));
  check_cr("flags after SUB", sub_cr, f100_cr_t'(mem_words[LSP_START + 16'd4]));
  report_test();
endtask

task automatic jump_skip();
  begin_program("jump_skip");
  emit(mem_ref(OP_LDA, 11'h000));
  emit(16'h5a5a);
  emit(mem_ref(OP_JMP, 11'h000));
  emit(16'h0018);
  emit(mem_ref(OP_STO, 11'h220));
  emit(HALT_WORD);
  prog_addr = 16'h0018;
  emit(mem_ref(OP_STO, 11'h221));
  emit(HALT_WORD);
  run_to_halt();
  check_word("jmp skipped store", fill_word(16'h0220), mem_words[16'h0220]);
  check_word("jmp target store", 16'h5a5a, mem_words[16'h0221]);
  report_test();
endtask

task automatic call_return();
  f100_cr_t zero_cr;
  int       i;
  begin_program("call_return");
  emit(mem_ref(OP_LDA, 11'h000));
  emit(16'h0003);
  emit(mem_ref(OP_CAL, 11'h000));
  emit(16'h0040);
  emit(mem_ref(OP_STO, 11'h230));
  emit(mem_ref(OP_LDA, 11'h000));
  emit(16'h0000);
  emit(mem_ref(OP_CAL, 11'h000));
  emit(16'h0050);
  emit(mem_ref(OP_CAL, 11'h000));
  emit(16'h0060);
  prog_addr = 16'h0040;
  emit(mem_ref(OP_ADD, 11'h000));
  emit(16'h0005);
  emit(RTN_WORD);
  // Changes the CR so that RTC has something to undo
  prog_addr = 16'h0050;
  emit(mem_ref(OP_LDA, 11'h000));
  emit(16'h8000);
  emit(RTC_WORD);
  prog_addr = 16'h0060;
  emit(HALT_WORD);
  run_to_halt();
  zero_cr   = '0;
  zero_cr.z = 1'b1;
  check_word("store after return", 16'h0003 + 16'h0005, mem_words[16'h0230]);
  // Every call leaves LSP+2 in word 0 and every return puts LSP back
  check_word("link stack writes", 16'd5, 16'(lsp_log.size()));
  for (i = 0; i < lsp_log.size(); i++)
    check_word("link stack pointer", (i % 2 == 0) ? LSP_START + 16'd2 : LSP_START,
               lsp_log[i]);
  check_word("return pc pushed", 16'h001b, mem_words[LSP_START + 16'd1]);
  check_cr("cr restored by rtc", zero_cr, f100_cr_t'(mem_words[LSP_START + 16'd2]));
  check_word("final link stack pointer", LSP_START + 16'd2, mem_words[`F100_LSP_ADDR]);
  report_test();
endtask

task automatic halt_backpressure();
  begin_program("halt_backpressure");
  emit(mem_ref(OP_LDA, 11'h000));
  emit(16'h0001);
  emit(mem_ref(OP_STO, 11'h240));
  // Endless jump to itself until the halt button
  emit(mem_ref(OP_JMP, 11'h000));
  emit(16'h0013);
  pulse_reset();
  repeat (60) @(negedge raw_clk);
  button_halt = 1'b0;
  while (!halted)
    @(negedge raw_clk);
  repeat (20) @(negedge raw_clk);
  if (!halted)
  begin
    $display("halt_backpressure: halted dropped while the button was held");
    test_errors++;
  end
  check_word("requests after halt", 16'h0000, 16'(late_requests));
  check_word("store before halt", 16'h0001, mem_words[16'h0240]);
  button_halt = 1'b1;
  report_test();
endtask

// ==== bench/f100_tb.sv ====
`timescale 1ns/1ps

`include "f100_settings.svh"

module f100_tb
  import f100_isa_pkg::*, f100_bus_pkg::*;
();

  localparam int unsigned W          = `F100_WORD_W;
  localparam int          CYCLES_MAX = 6 * 400;
  localparam logic [15:0] HALT_WORD  = 16'h0400;
  localparam logic [15:0] RTN_WORD   = 16'h3000;
  localparam logic [15:0] RTC_WORD   = 16'h3800;
  localparam logic [15:0] LSP_START  = 16'h0100;

  logic     raw_clk = 1'b0;
  logic     button_reset;
  logic     button_halt;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp = '0;
  logic     halted;

  // Program image copied into the memory while reset is held
  logic [W-1:0] boot_image [0:65535];
  logic [W-1:0] mem_words [0:65535];
  mem_req_t     req_queue [$];
  int           delay_queue [$];
  logic [W-1:0] lsp_log [$];
  logic [31:0]  lfsr = 32'h6973;
  logic [15:0]  prog_addr;
  string        test_name = "";
  int           bus_errors = 0;
  int           late_requests = 0;
  int           cycles = 0;
  int           test_errors = 0;
  int           test_fails = 0;
  int           tests_run = 0;
  int           bus_errors_at_start = 0;

  f100_cpu f100_cpu_inst (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp),
    .halted       (halted)
  );

  always #4 raw_clk = ~raw_clk;

  // Taps of x^32 + x^22 + x^2 + x + 1
  // New bit enters at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Memory model sampled and driven on the falling edge
  always @(negedge raw_clk)
  begin
    mem_req_t head;
    logic     answered;
    int       delay;
    int       a;
    answered = 1'b0;
    mem_rsp  = '0;
    if (!button_reset)
    begin
      for (a = 0; a < 65536; a++)
        mem_words[a[15:0]] = boot_image[a[15:0]];
      req_queue.delete();
      delay_queue.delete();
      lsp_log.delete();
      late_requests = 0;
    end
    else
    begin
      // Oldest request is answered once its wait runs out
      if (req_queue.size() > 0)
      begin
        if (delay_queue[0] == 0)
        begin
          head = req_queue.pop_front();
          void'(delay_queue.pop_front());
          answered      = 1'b1;
          mem_rsp.valid = 1'b1;
          if (head.write)
          begin
            mem_words[head.addr] = head.wdata;
            if (head.addr == `F100_LSP_ADDR)
              lsp_log.push_back(head.wdata);
          end
          else
            mem_rsp.rdata = mem_words[head.addr];
        end
        else
          delay_queue[0] = delay_queue[0] - 1;
      end
      if (mem_req.valid)
      begin
        // A response driven on this edge is not yet seen by the port
        if (req_queue.size() + int'(answered) >= `F100_MEM_CREDITS)
        begin
          $display("Error: memory request while %0d responses are still owed",
                   `F100_MEM_CREDITS);
          bus_errors++;
        end
        if (halted)
        begin
          $display("Error: memory request issued after the CPU halted");
          bus_errors++;
          late_requests++;
        end
        // Two LFSR bits give 0 to 3 idle cycles
        lfsr  = lfsr_next(lfsr);
        delay = lfsr[0] ? 2 : 0;
        lfsr  = lfsr_next(lfsr);
        delay = delay + int'(lfsr[0]);
        req_queue.push_back(mem_req);
        delay_queue.push_back(delay);
      end
    end
  end

  always @(posedge raw_clk)
  begin
    cycles++;
    if (cycles >= CYCLES_MAX)
    begin
      $display("Timeout: run did not finish within %0d cycles", CYCLES_MAX);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [W-1:0] expected,
                            input logic [W-1:0] actual);
    if (actual !== expected)
    begin
      $display("Fail %s (%s): expected %h, got %h", test_name, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_cr(input string name, input f100_cr_t expected,
                          input f100_cr_t actual);
    if (actual !== expected)
    begin
      $display("Fail %s (%s): expected CR %h (FMCSVZI %b), got %h (FMCSVZI %b)",
               test_name, name, expected, expected[6:0], actual, actual[6:0]);
      test_errors++;
    end
  endtask

  `include "f100_tb_tests.svh"

  initial
  begin
    button_reset = 1'b0;
    button_halt  = 1'b1;
    lda_sto_moves();
    alu_results();
    flag_push();
    jump_skip();
    call_return();
    halt_backpressure();
    $display("Summary: %0d tests, %0d failed, %0d bus errors",
             tests_run, test_fails, bus_errors);
    if (test_fails == 0 && bus_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== common/f100_bus_pkg.sv ====
package f100_bus_pkg;

  `include "f100_settings.svh"

  // One cycle request toward the memory
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [`F100_WORD_W-1:0] addr;
    logic [`F100_WORD_W-1:0] wdata;
  } mem_req_t;

  // In-order answer, one per request
  typedef struct packed {
    logic                    valid;
    logic [`F100_WORD_W-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== common/f100_isa_pkg.sv ====
package f100_isa_pkg;

  // Major opcodes, instruction bits 15..12
  typedef enum logic [3:0] {
    OP_SPECIAL = 4'h0,
    OP_CAL     = 4'h2,
    OP_STO     = 4'h4,
    OP_LDA     = 4'h8,
    OP_ADD     = 4'h9,
    OP_SUB     = 4'ha,
    OP_CMP     = 4'hb,
    OP_AND     = 4'hc,
    OP_NEQ     = 4'hd,
    OP_JMP     = 4'hf
  } f100_op_e;

  // Memory reference format, N of zero selects the inline word
  typedef struct packed {
    f100_op_e    op;
    logic        i;
    logic [10:0] n;
  } f100_instr_t;

  typedef struct packed {
    logic [8:0] unused;
    logic       f;
    logic       m;
    logic       c;
    logic       s;
    logic       v;
    logic       z;
    logic       i;
  } f100_cr_t;

  // Sequencer states, each memory state both issues and waits
  typedef enum logic [3:0] {
    ST_FETCH,
    ST_DECODE,
    ST_OPER,
    ST_EXECUTE,
    ST_STORE,
    ST_LSP_READ,
    ST_PUSH_PC,
    ST_PUSH_CR,
    ST_POP_CR,
    ST_POP_PC,
    ST_LSP_WRITE,
    ST_HALTED
  } f100_state_e;

endpackage

// ==== common/f100_settings.svh ====
`ifndef F100_SETTINGS_SVH
`define F100_SETTINGS_SVH

// Data path and address width
`define F100_WORD_W 16

// First instruction fetch after reset
`define F100_RESET_PC 16'h0010

// Word holding the link stack pointer
`define F100_LSP_ADDR 16'h0000

// Outstanding memory requests the port may issue
`define F100_MEM_CREDITS 2

`endif

// ==== core/f100_alu.sv ====
`timescale 1ns/1ps

`include "f100_settings.svh"

module f100_alu
  import f100_isa_pkg::*;
(
  input  f100_op_e                alu_op,
  input  logic [`F100_WORD_W-1:0] alu_a,
  input  logic [`F100_WORD_W-1:0] alu_b,
  input  f100_cr_t                cr_in,
  output logic [`F100_WORD_W-1:0] alu_result,
  output f100_cr_t                alu_flags
);

  localparam int unsigned W = `F100_WORD_W;

  logic [W:0] sum;
  logic [W:0] diff;
  logic [W:0] wide;
  logic       sets_flags;

  // Operand order as on the F100, memory word first
  assign sum  = {1'b0, alu_b} + {1'b0, alu_a};
  assign diff = {1'b0, alu_b} - {1'b0, alu_a};

  always_comb
  begin
    wide       = {1'b0, alu_b};
    sets_flags = 1'b1;
    case (alu_op)
      OP_ADD:         wide = sum;
      OP_SUB, OP_CMP: wide = diff;
      OP_AND:         wide = {1'b0, alu_a & alu_b};
      OP_NEQ:         wide = {1'b0, alu_a ^ alu_b};
      OP_STO:         wide = {1'b0, alu_a};
      OP_LDA, OP_JMP: wide = {1'b0, alu_b};
      default:        sets_flags = 1'b0;
    endcase
  end

  assign alu_result = wide[W-1:0];

  always_comb
  begin
    alu_flags = cr_in;
    if (sets_flags)
    begin
      alu_flags.c = wide[W];
      alu_flags.s = wide[W-1];
      alu_flags.z = (wide[W-1:0] == '0);
    end
    // Overflow only on the arithmetic ops
    if (alu_op == OP_ADD)
      alu_flags.v = (alu_a[W-1] == alu_b[W-1]) && (wide[W-1] != alu_a[W-1]);
    else if (alu_op == OP_SUB || alu_op == OP_CMP)
      alu_flags.v = (alu_a[W-1] != alu_b[W-1]) && (wide[W-1] == alu_a[W-1]);
  end

endmodule

// ==== core/f100_control.sv ====
`timescale 1ns/1ps

`include "f100_settings.svh"

module f100_control
  import f100_isa_pkg::*, f100_bus_pkg::*;
(
  input  logic                    raw_clk,
  input  logic                    button_reset,
  input  logic                    button_halt,
  output mem_req_t                core_req,
  input  logic                    req_ready,
  input  mem_rsp_t                mem_rsp,
  output f100_op_e                alu_op,
  output logic [`F100_WORD_W-1:0] alu_a,
  output logic [`F100_WORD_W-1:0] alu_b,
  output f100_cr_t                alu_cr,
  input  logic [`F100_WORD_W-1:0] alu_result,
  input  f100_cr_t                alu_flags,
  output logic                    halted
);

  localparam int unsigned W = `F100_WORD_W;

  f100_state_e state_q;
  f100_instr_t instr_q;
  f100_cr_t    cr_q;
  logic [W-1:0] pc_q;
  logic [W-1:0] acc_q;
  logic [W-1:0] ea_q;
  logic [W-1:0] lsp_q;
  logic [W-1:0] operand_q;
  logic         pending_q;

  logic         mem_state;
  logic         rsp_done;
  logic [15:0]  instr_bits;
  logic         is_halt;
  logic         is_ret;

  assign instr_bits = instr_q;
  // HALT is 0000 01xx
  // RTN and RTC share opcode 3
  assign is_halt  = (instr_bits[15:10] == 6'b000001);
  assign is_ret   = (instr_bits[15:12] == 4'h3);
  assign rsp_done = pending_q && mem_rsp.valid;

  assign alu_op = instr_q.op;
  assign alu_a  = acc_q;
  assign alu_b  = operand_q;
  assign alu_cr = cr_q;
  assign halted = (state_q == ST_HALTED);

  // Address and data follow the state
  always_comb
  begin
    core_req  = '0;
    mem_state = 1'b1;
    case (state_q)
      ST_FETCH:     core_req.addr = pc_q;
      ST_OPER:      core_req.addr = ea_q;
      ST_STORE:
      begin
        core_req.write = 1'b1;
        core_req.addr  = ea_q;
        core_req.wdata = acc_q;
      end
      ST_LSP_READ:  core_req.addr = `F100_LSP_ADDR;
      ST_PUSH_PC:
      begin
        core_req.write = 1'b1;
        core_req.addr  = lsp_q + W'(1);
        core_req.wdata = pc_q;
      end
      ST_PUSH_CR:
      begin
        core_req.write = 1'b1;
        core_req.addr  = lsp_q + W'(2);
        core_req.wdata = cr_q;
      end
      ST_POP_CR:    core_req.addr = lsp_q;
      ST_POP_PC:    core_req.addr = lsp_q - W'(1);
      ST_LSP_WRITE:
      begin
        core_req.write = 1'b1;
        core_req.addr  = `F100_LSP_ADDR;
        core_req.wdata = is_ret ? lsp_q - W'(2) : lsp_q + W'(2);
      end
      default:      mem_state = 1'b0;
    endcase
    // One access at a time and none once halt is pressed
    core_req.valid = mem_state && !pending_q && req_ready && button_halt;
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state_q   <= ST_FETCH;
      pending_q <= 1'b0;
      pc_q      <= `F100_RESET_PC;
      acc_q     <= '0;
      cr_q      <= '0;
    end
    else
    begin
      if (core_req.valid)
        pending_q <= 1'b1;
      else if (rsp_done)
        pending_q <= 1'b0;

      // Halt waits for the access in flight to drain
      if (!button_halt && !pending_q)
        state_q <= ST_HALTED;
      else
        case (state_q)
          ST_FETCH:
          begin
            if (core_req.valid)
              pc_q <= pc_q + W'(1);
            if (rsp_done)
            begin
              instr_q <= f100_instr_t'(mem_rsp.rdata);
              state_q <= ST_DECODE;
            end
          end
          ST_DECODE:
          begin
            if (is_halt)
              state_q <= ST_HALTED;
            else if (is_ret)
              state_q <= ST_LSP_READ;
            else
              case (instr_q.op)
                OP_LDA, OP_STO, OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_NEQ, OP_JMP, OP_CAL:
                begin
                  // Immediate operand sits after the instruction
                  if (instr_q.n == '0)
                  begin
                    ea_q <= pc_q;
                    pc_q <= pc_q + W'(1);
                  end
                  else
                    ea_q <= {{(W - 11){1'b0}}, instr_q.n};
                  state_q <= (instr_q.op == OP_STO) ? ST_EXECUTE : ST_OPER;
                end
                default:
                  state_q <= ST_FETCH;
              endcase
          end
          ST_OPER:
          begin
            if (rsp_done)
            begin
              operand_q <= mem_rsp.rdata;
              state_q   <= ST_EXECUTE;
            end
          end
          ST_EXECUTE:
          begin
            state_q <= ST_FETCH;
            case (instr_q.op)
              OP_CMP:
                cr_q <= alu_flags;
              OP_JMP:
              begin
                cr_q <= alu_flags;
                pc_q <= alu_result;
              end
              OP_STO:
              begin
                cr_q    <= alu_flags;
                state_q <= ST_STORE;
              end
              OP_CAL:
                state_q <= ST_LSP_READ;
              default:
              begin
                acc_q <= alu_result;
                cr_q  <= alu_flags;
              end
            endcase
          end
          ST_STORE:
            if (rsp_done)
              state_q <= ST_FETCH;
          ST_LSP_READ:
          begin
            if (rsp_done)
            begin
              lsp_q   <= mem_rsp.rdata;
              state_q <= is_ret ? ST_POP_CR : ST_PUSH_PC;
            end
          end
          ST_PUSH_PC:
            if (rsp_done)
              state_q <= ST_PUSH_CR;
          ST_PUSH_CR:
            if (rsp_done)
              state_q <= ST_LSP_WRITE;
          ST_POP_CR:
          begin
            if (rsp_done)
            begin
              // Only RTC puts the saved CR back
              if (instr_q.i)
                cr_q <= f100_cr_t'(mem_rsp.rdata);
              state_q <= ST_POP_PC;
            end
          end
          ST_POP_PC:
          begin
            if (rsp_done)
            begin
              pc_q    <= mem_rsp.rdata;
              state_q <= ST_LSP_WRITE;
            end
          end
          ST_LSP_WRITE:
          begin
            if (rsp_done)
            begin
              // A call clears M once the caller's CR is saved
              if (!is_ret)
              begin
                pc_q   <= operand_q;
                cr_q.m <= 1'b0;
              end
              state_q <= ST_FETCH;
            end
          end
          default:
            state_q <= ST_HALTED;
        endcase
    end
  end

endmodule

// ==== hw/f100_cpu.sv ====
`timescale 1ns/1ps

`include "f100_settings.svh"

module f100_cpu
  import f100_isa_pkg::*, f100_bus_pkg::*;
(
  input  logic     raw_clk,
  input  logic     button_reset,
  input  logic     button_halt,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp,
  output logic     halted
);

  mem_req_t                core_req;
  logic                    req_ready;
  f100_op_e                alu_op;
  logic [`F100_WORD_W-1:0] alu_a;
  logic [`F100_WORD_W-1:0] alu_b;
  logic [`F100_WORD_W-1:0] alu_result;
  f100_cr_t                alu_cr;
  f100_cr_t                alu_flags;

  f100_control f100_control_inst (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .core_req     (core_req),
    .req_ready    (req_ready),
    .mem_rsp      (mem_rsp),
    .alu_op       (alu_op),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .alu_cr       (alu_cr),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .halted       (halted)
  );

  f100_alu f100_alu_inst (
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .cr_in      (alu_cr),
    .alu_result (alu_result),
    .alu_flags  (alu_flags)
  );

  // Response feeds both the credit count and the core
  mem_credit_port mem_credit_port_inst (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .core_req     (core_req),
    .req_ready    (req_ready),
    .mem_rsp      (mem_rsp),
    .mem_req      (mem_req)
  );

endmodule

// ==== hw/mem_credit_port.sv ====
`timescale 1ns/1ps

`include "f100_settings.svh"

module mem_credit_port
  import f100_bus_pkg::*;
(
  input  logic     raw_clk,
  input  logic     button_reset,
  input  mem_req_t core_req,
  output logic     req_ready,
  input  mem_rsp_t mem_rsp,
  output mem_req_t mem_req
);

  localparam int unsigned CREDITS = `F100_MEM_CREDITS;
  localparam int unsigned CNT_W   = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] credits_q;
  mem_req_t         req_q;
  logic             issue;

  // Credit is taken as the request is captured
  assign req_ready = (credits_q != '0);
  assign issue     = core_req.valid && req_ready;
  assign mem_req   = req_q;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      credits_q   <= CNT_W'(CREDITS);
      req_q.valid <= 1'b0;
    end
    else
    begin
      req_q.valid <= issue;
      // Issue and return in one cycle cancel out
      case ({issue, mem_rsp.valid})
        2'b10:   credits_q <= credits_q - CNT_W'(1);
        2'b01:   credits_q <= credits_q + CNT_W'(1);
        default: credits_q <= credits_q;
      endcase
    end

    if (issue)
    begin
      req_q.write <= core_req.write;
      req_q.addr  <= core_req.addr;
      req_q.wdata <= core_req.wdata;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+common
+incdir+bench
common/f100_isa_pkg.sv
common/f100_bus_pkg.sv
core/f100_alu.sv
core/f100_control.sv
hw/mem_credit_port.sv
hw/f100_cpu.sv
bench/f100_tb.sv
